// ==== sim.f ====
sdram_pkg.sv
sdram_ctlif.sv
sdram_mgmt.sv
sdram_cmd_mux.sv
sdram_ctrl_top.sv
tb_sdram_ctrl.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS := --binary --timing --assert -j 0
TOP := tb_sdram_ctrl
FILELIST := sim.f
LOG := sim.log

BIN := obj_dir/V$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST OK" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== tb_sdram_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_sdram_ctrl import sdram_pkg::*; ();

	localparam logic csr_addr = 1'b0;
	localparam int aw = 12;
	localparam int cw = 8;
	// about 80 requests of up to 70 cycles each, 600 idle cycles and the csr phases.
	localparam int timeout_cycles = 20000;

	typedef struct packed {
		logic we;
		logic [2+aw+cw-1:0] adr;
	} req_t;

	logic sys_clk;
	logic sys_rst;
	logic [2:0] csr_a;
	logic csr_we;
	logic [15:0] csr_di;
	logic [15:0] csr_do;
	logic access_stb;
	logic access_we;
	logic [2+aw+cw-1:0] access_adr;
	logic access_ack;
	logic sdram_cke;
	logic sdram_cs_n;
	logic sdram_ras_n;
	logic sdram_cas_n;
	logic sdram_we_n;
	logic [aw-1:0] sdram_adr;
	logic [1:0] sdram_ba;
	logic [3:0] pin_code;

	logic [15:0] m_regs [4]; // mirror of the four csr registers as they read back.
	req_t req_q [$];
	req_t cur;
	req_t r;
	csr_word_t tw;
	csr_word_t cmd_word;
	logic [3:0] last_code;
	logic [3:0] open_banks;
	bit mon_on;
	int cyc = 0;
	int phase, act_cyc, rw_cyc, ack_cyc, last_cyc, last_ref_cyc;
	int ack_count, req_count, ref_count;
	int rp, rcd, cas, rfc, wr, refi;

	sdram_ctrl_top #(
		.csr_addr(csr_addr),
		.sdram_addrdepth(aw),
		.sdram_columndepth(cw)
	) i_dut (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.csr_a(csr_a),
		.csr_we(csr_we),
		.csr_di(csr_di),
		.csr_do(csr_do),
		.access_stb(access_stb),
		.access_we(access_we),
		.access_adr(access_adr),
		.access_ack(access_ack),
		.sdram_cke(sdram_cke),
		.sdram_cs_n(sdram_cs_n),
		.sdram_ras_n(sdram_ras_n),
		.sdram_cas_n(sdram_cas_n),
		.sdram_we_n(sdram_we_n),
		.sdram_adr(sdram_adr),
		.sdram_ba(sdram_ba)
	);

	assign pin_code = {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n};

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	task automatic stop_failed();
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
		$display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
		stop_failed();
	endtask

	task automatic problem(input string what);
		$display("[ERROR] %0t %s", $time, what);
		stop_failed();
	endtask

	always @(posedge sys_clk) begin
		cyc <= cyc + 1;
		if (cyc == timeout_cycles)
			problem("timeout, the run did not finish in time.");
	end

	// bits that exist in each register. the rest read as zero.
	function automatic logic [15:0] reg_mask(input logic [1:0] idx);
		case (idx)
			reg_sys: return 16'h0007;
			reg_cmd: return 16'hfff0;
			reg_tim: return 16'h1fff;
			default: return 16'h07ff;
		endcase
	endfunction

	task automatic csr_write(input logic [2:0] a, input logic [15:0] d);
		@(negedge sys_clk);
		csr_a = a;
		csr_we = 1'b1;
		csr_di = d;
		@(negedge sys_clk);
		csr_we = 1'b0;
		if (a[2] == csr_addr)
			m_regs[a[1:0]] = d & reg_mask(a[1:0]);
	endtask

	task automatic csr_read(input logic [2:0] a, input logic [15:0] exp);
		@(negedge sys_clk);
		csr_a = a;
		csr_we = 1'b0;
		@(negedge sys_clk);
		assert (csr_do == exp) else mismatch("csr_do", 32'(csr_do), 32'(exp));
		assert (sdram_cke == m_regs[reg_sys][2])
			else mismatch("sdram_cke", 32'(sdram_cke), 32'(m_regs[reg_sys][2]));
	endtask

	task automatic run_access(input req_t req);
		@(negedge sys_clk);
		access_stb = 1'b1;
		access_we = req.we;
		access_adr = req.adr;
		req_q.push_back(req);
		req_count++;
		@(negedge sys_clk);
		while (!access_ack)
			@(negedge sys_clk);
		access_stb = 1'b0;
	endtask

	////////////////////
	// pin monitor.
	////////////////////

	always @(negedge sys_clk) begin
		if (mon_on) begin
			tw = m_regs[reg_refi];
			refi = int'(tw.refi.refi);
			tw = m_regs[reg_tim];
			rp = int'(tw.timing.rp);
			rcd = int'(tw.timing.rcd);
			cas = int'(tw.timing.cas);
			rfc = int'(tw.timing.rfc);
			wr = int'(tw.timing.wr);
			if (access_ack) begin
				ack_count++;
				ack_cyc = cyc;
			end
			assert (cyc - last_ref_cyc <= refi + rp + rfc + 40)
				else problem("refresh interval exceeded.");
			if (pin_code != cmd_nop) begin
				if (last_code == cmd_precharge)
					assert (cyc - last_cyc >= rp + 1) else problem("precharge gap too short.");
				if (last_code == cmd_refresh)
					assert (cyc - last_cyc >= rfc + 1) else problem("refresh gap too short.");
				case (pin_code)
					cmd_active: begin
						assert (phase == 0 && req_q.size() > 0)
							else problem("activate without a pending request.");
						cur = req_q.pop_front();
						assert (sdram_ba == cur.adr[2+aw+cw-1 -: 2])
							else mismatch("sdram_ba", 32'(sdram_ba),
								32'(cur.adr[2+aw+cw-1 -: 2]));
						assert (sdram_adr == cur.adr[cw +: aw])
							else mismatch("sdram_adr", 32'(sdram_adr), 32'(cur.adr[cw +: aw]));
						open_banks[sdram_ba] = 1'b1;
						act_cyc = cyc;
						phase = 1;
					end
					cmd_read, cmd_write: begin
						assert (phase == 1)
							else problem("read or write without an open row.");
						assert (pin_code == (cur.we ? cmd_write : cmd_read))
							else mismatch("command", 32'(pin_code),
								32'(cur.we ? cmd_write : cmd_read));
						assert (sdram_adr == aw'(cur.adr[cw-1:0]))
							else mismatch("sdram_adr", 32'(sdram_adr), 32'(cur.adr[cw-1:0]));
						assert (cyc - act_cyc >= rcd + 1)
							else problem("activate to access too short.");
						assert (cyc == ack_cyc + 1)
							else problem("access_ack not one cycle ahead.");
						rw_cyc = cyc;
						phase = 2;
					end
					cmd_precharge: begin
						if (sdram_adr[10]) begin
							assert (phase == 0) else problem("precharge all during an access.");
							open_banks = 4'd0;
						end else begin
							assert (phase == 2 && sdram_ba == cur.adr[2+aw+cw-1 -: 2])
								else problem("precharge out of order or on the wrong bank.");
							assert (cyc - rw_cyc >= (cur.we ? wr + 1 : cas + 2))
								else problem("access to precharge too short.");
							open_banks[sdram_ba] = 1'b0;
							phase = 0;
						end
					end
					cmd_refresh: begin
						assert (open_banks == 4'd0) else problem("refresh with a bank open.");
						ref_count++;
						last_ref_cyc = cyc;
					end
					default: problem("unexpected command on the sdram pins.");
				endcase
				last_code = pin_code;
				last_cyc = cyc;
			end
		end
	end

	////////////////////
	// stimulus.
	////////////////////

	initial begin
		void'($urandom(32'hb3a2));
		sys_rst = 1'b1;
		csr_a = 3'd0;
		csr_we = 1'b0;
		csr_di = 16'd0;
		access_stb = 1'b0;
		access_we = 1'b0;
		access_adr = '0;
		mon_on = 1'b0;
		phase = 0;
		last_code = cmd_nop;
		open_banks = 4'd0;
		m_regs[reg_sys] = 16'h0003;
		m_regs[reg_cmd] = 16'h0000;
		m_regs[reg_tim] = 16'h1412; // wr 2, rfc 8, cas 0, rcd 2, rp 2.
		m_regs[reg_refi] = 16'd740;
		repeat (2) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst = 1'b0;

		for (int i = 0; i < 4; i++)
			csr_read({csr_addr, 2'(i)}, m_regs[i]);
		repeat (40) begin
			csr_a = 3'($urandom);
			csr_write(csr_a, 16'($urandom));
			csr_read({csr_addr, csr_a[1:0]}, m_regs[csr_a[1:0]]);
			csr_read({~csr_addr, csr_a[1:0]}, 16'h0000);
		end

		csr_write({csr_addr, reg_sys}, 16'h0005);
		repeat (30) begin
			cmd_word = 16'($urandom);
			csr_write({csr_addr, reg_cmd}, cmd_word);
			assert (pin_code == cmd_nop) else mismatch("command", 32'(pin_code), 32'(cmd_nop));
			@(negedge sys_clk);
			assert (pin_code == ~{cmd_word.bypass_cmd.cs, cmd_word.bypass_cmd.ras,
				cmd_word.bypass_cmd.cas, cmd_word.bypass_cmd.we})
				else mismatch("command", 32'(pin_code), 32'(~{cmd_word.bypass_cmd.cs,
				cmd_word.bypass_cmd.ras, cmd_word.bypass_cmd.cas, cmd_word.bypass_cmd.we}));
			assert (sdram_adr == cmd_word.bypass_cmd.adr)
				else mismatch("sdram_adr", 32'(sdram_adr), 32'(cmd_word.bypass_cmd.adr));
			assert (sdram_ba == 2'b00) else mismatch("sdram_ba", 32'(sdram_ba), 32'd0);
			repeat (1 + int'($urandom % 4)) begin
				@(negedge sys_clk);
				assert (pin_code == cmd_nop)
					else mismatch("command", 32'(pin_code), 32'(cmd_nop));
			end
		end

		csr_write({csr_addr, reg_tim}, 16'($urandom) & 16'h1fff);
		csr_write({csr_addr, reg_refi}, 16'd64 + 16'($urandom % 200));
		csr_write({csr_addr, reg_sys}, 16'h0004); // sequencer takes over the pins.
		last_ref_cyc = cyc;
		mon_on = 1'b1;
		repeat (80) begin
			r.we = 1'($urandom);
			r.adr = (2+aw+cw)'($urandom);
			run_access(r);
			repeat (int'($urandom % 12))
				@(negedge sys_clk);
		end
		repeat (600)
			@(negedge sys_clk);
		assert (ack_count == req_count) else mismatch("access_ack count", 32'(ack_count),
			32'(req_count));
		assert (ref_count > 0) else problem("no refresh was seen.");
		assert (phase == 0 && req_q.size() == 0) else problem("an access did not complete.");

		mon_on = 1'b0;
		csr_write({csr_addr, reg_sys}, 16'h0005);
		@(negedge sys_clk);
		repeat (60) begin
			@(negedge sys_clk);
			assert (pin_code == cmd_nop) else mismatch("command", 32'(pin_code), 32'(cmd_nop));
		end

		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sdram_ctrl_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module sdram_ctrl_top import sdram_pkg::*; #(
	parameter logic csr_addr = 1'b0,
	parameter int sdram_addrdepth = 12,
	parameter int sdram_columndepth = 8
) (
	input logic sys_clk,
	input logic sys_rst,

	input logic [2:0] csr_a,
	input logic csr_we,
	input logic [15:0] csr_di,
	output logic [15:0] csr_do,

	input logic access_stb,
	input logic access_we,
	input logic [2+sdram_addrdepth+sdram_columndepth-1:0] access_adr,
	output logic access_ack,

	output logic sdram_cke,
	output logic sdram_cs_n,
	output logic sdram_ras_n,
	output logic sdram_cas_n,
	output logic sdram_we_n,
	output logic [sdram_addrdepth-1:0] sdram_adr,
	output logic [1:0] sdram_ba
);

	logic bypass;
	logic sdram_rst;
	sdram_cmd_t bypass_cmd;
	sdram_cmd_t mgmt_cmd;
	sdram_cmd_t sdram_pins;
	sdram_timing_t timing;

	sdram_ctlif #(
		.csr_addr(csr_addr),
		.sdram_addrdepth(sdram_addrdepth)
	) i_ctlif (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.csr_a(csr_a),
		.csr_we(csr_we),
		.csr_di(csr_di),
		.csr_do(csr_do),
		.bypass(bypass),
		.sdram_rst(sdram_rst),
		.sdram_cke(sdram_cke),
		.bypass_cmd(bypass_cmd),
		.timing(timing)
	);

	sdram_mgmt #(
		.sdram_addrdepth(sdram_addrdepth),
		.sdram_columndepth(sdram_columndepth)
	) i_mgmt (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.bypass(bypass),
		.sdram_rst(sdram_rst),
		.timing(timing),
		.access_stb(access_stb),
		.access_we(access_we),
		.access_adr(access_adr),
		.access_ack(access_ack),
		.mgmt_cmd(mgmt_cmd)
	);

	sdram_cmd_mux i_cmd_mux (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.bypass(bypass),
		.sdram_rst(sdram_rst),
		.bypass_cmd(bypass_cmd),
		.mgmt_cmd(mgmt_cmd),
		.sdram_pins(sdram_pins)
	);

	assign sdram_cs_n = sdram_pins.cs_n;
	assign sdram_ras_n = sdram_pins.ras_n;
	assign sdram_cas_n = sdram_pins.cas_n;
	assign sdram_we_n = sdram_pins.we_n;
	assign sdram_ba = sdram_pins.ba;
	assign sdram_adr = sdram_pins.adr[sdram_addrdepth-1:0]; // upper struct bits stay unused.

endmodule

`default_nettype wire

// ==== sdram_cmd_mux.sv ====
`timescale 1ns/1ns
`default_nettype none

module sdram_cmd_mux import sdram_pkg::*; (
	input logic sys_clk,
	input logic sys_rst,
	input logic bypass,
	input logic sdram_rst,
	input sdram_cmd_t bypass_cmd,
	input sdram_cmd_t mgmt_cmd,
	output sdram_cmd_t sdram_pins
);

	////////////////////
	// pin register.
	////////////////////

	// every pin leaves a flop, so no decode glitch reaches the device.
	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			sdram_pins <= nop_cmd;
		else if (bypass)
			sdram_pins <= bypass_cmd; // init commands pass even while sdram_rst is set.
		else if (sdram_rst)
			sdram_pins <= nop_cmd;
		else
			sdram_pins <= mgmt_cmd;
	end

	assert property (@(posedge sys_clk)
		sys_rst |=> cmd_code(sdram_pins) == cmd_nop);

endmodule

`default_nettype wire

// ==== sdram_mgmt.sv ====
`timescale 1ns/1ns
`default_nettype none

module sdram_mgmt import sdram_pkg::*; #(
	parameter int sdram_addrdepth = 12,
	parameter int sdram_columndepth = 8
) (
	input logic sys_clk,
	input logic sys_rst,
	input logic bypass,
	input logic sdram_rst,
	input sdram_timing_t timing,
	input logic access_stb,
	input logic access_we,
	input logic [2+sdram_addrdepth+sdram_columndepth-1:0] access_adr,
	output logic access_ack,
	output sdram_cmd_t mgmt_cmd
);

	localparam int adr_width = 2 + sdram_addrdepth + sdram_columndepth;
	localparam logic [max_addrdepth-1:0] pre_all_adr = max_addrdepth'(1 << 10);

	typedef enum logic [2:0] {
		s_idle,
		s_act,     // row open, waiting for rcd.
		s_rw,      // read or write issued, waiting for wr or cas.
		s_pre,     // precharge issued, waiting for rp.
		s_ref_pre, // precharge all before a refresh.
		s_ref      // refresh issued, waiting for rfc.
	} state_t;

	state_t state;
	logic [3:0] wait_cnt;
	logic wait_done;
	logic [10:0] refi_cnt;
	logic ref_pending;
	logic ref_take;
	logic act_take;
	logic hold;
	logic [1:0] open_ba;
	logic [1:0] req_ba;
	logic [sdram_addrdepth-1:0] req_row;
	logic [sdram_columndepth-1:0] req_col;
	logic [max_addrdepth-1:0] row_adr;
	logic [max_addrdepth-1:0] col_adr;

	assign hold = bypass | sdram_rst;
	assign wait_done = wait_cnt == 4'd0;
	assign ref_take = (state == s_idle) && ref_pending;
	assign act_take = (state == s_idle) && !ref_pending && access_stb;

	// request address is {bank, row, column}.
	assign req_ba = access_adr[adr_width-1 -: 2];
	assign req_row = access_adr[sdram_columndepth +: sdram_addrdepth];
	assign req_col = access_adr[sdram_columndepth-1:0];
	assign row_adr = max_addrdepth'(req_row);

	always_comb begin
		col_adr = max_addrdepth'(req_col);
		col_adr[10] = 1'b0; // no auto-precharge.
	end

	////////////////////
	// refresh timer.
	////////////////////

	always_ff @(posedge sys_clk) begin
		if (sys_rst || hold) begin
			refi_cnt <= timing.refi;
			ref_pending <= 1'b0;
		end else begin
			if (ref_take)
				ref_pending <= 1'b0;
			if (refi_cnt == 11'd0) begin
				refi_cnt <= timing.refi;
				ref_pending <= 1'b1; // a fresh expiry wins over the clear.
			end else begin
				refi_cnt <= refi_cnt - 11'd1;
			end
		end
	end

	// bank of the open row, needed again for the precharge after the ack.
	always_ff @(posedge sys_clk) begin
		if (act_take)
			open_ba <= req_ba;
	end

	////////////////////
	// command sequencer.
	////////////////////

	always_ff @(posedge sys_clk) begin
		if (sys_rst || hold) begin
			state <= s_idle;
			wait_cnt <= 4'd0;
			access_ack <= 1'b0;
			mgmt_cmd <= nop_cmd;
		end else begin
			access_ack <= 1'b0;
			mgmt_cmd <= nop_cmd;
			if (!wait_done)
				wait_cnt <= wait_cnt - 4'd1;
			case (state)
				s_idle: begin
					if (ref_take) begin
						mgmt_cmd <= make_cmd(cmd_precharge, 2'b00, pre_all_adr);
						wait_cnt <= 4'(timing.rp);
						state <= s_ref_pre;
					end else if (act_take) begin
						mgmt_cmd <= make_cmd(cmd_active, req_ba, row_adr);
						wait_cnt <= 4'(timing.rcd);
						state <= s_act;
					end
				end
				s_act: begin
					if (wait_done) begin
						mgmt_cmd <= make_cmd(access_we ? cmd_write : cmd_read, open_ba, col_adr);
						access_ack <= 1'b1;
						wait_cnt <= access_we ? 4'(timing.wr) : 4'(timing.cas) + 4'd1;
						state <= s_rw;
					end
				end
				s_rw: begin
					if (wait_done) begin
						mgmt_cmd <= make_cmd(cmd_precharge, open_ba, '0);
						wait_cnt <= 4'(timing.rp);
						state <= s_pre;
					end
				end
				s_ref_pre: begin
					if (wait_done) begin
						mgmt_cmd <= make_cmd(cmd_refresh, 2'b00, '0);
						wait_cnt <= timing.rfc;
						state <= s_ref;
					end
				end
				s_pre, s_ref: begin
					if (wait_done)
						state <= s_idle;
				end
				default: state <= s_idle;
			endcase
		end
	end

	// software owns the pins in bypass.
	assert property (@(posedge sys_clk) disable iff (sys_rst)
		bypass |=> cmd_code(mgmt_cmd) == cmd_nop);

	assert property (@(posedge sys_clk) disable iff (sys_rst)
		access_ack |=> !access_ack);

endmodule

`default_nettype wire

// ==== sdram_ctlif.sv ====
`timescale 1ns/1ns
`default_nettype none

module sdram_ctlif import sdram_pkg::*; #(
	parameter logic csr_addr = 1'b0,
	parameter int sdram_addrdepth = 12
) (
	input logic sys_clk,
	input logic sys_rst,
	input logic [2:0] csr_a,
	input logic csr_we,
	input logic [15:0] csr_di,
	output logic [15:0] csr_do,
	output logic bypass,
	output logic sdram_rst,
	output logic sdram_cke,
	output sdram_cmd_t bypass_cmd,
	output sdram_timing_t timing
);

	logic csr_sel;
	logic cmd_wr;
	csr_word_t wr_word;
	csr_word_t rd_word;
	logic [3:0] cmd_q;
	logic [11:0] cmd_adr; // last address written to the command register.
	logic [max_addrdepth-1:0] cmd_adr_ext;

	assign csr_sel = csr_a[2] == csr_addr;
	assign cmd_wr = csr_sel && csr_we && (csr_a[1:0] == reg_cmd);
	assign wr_word = csr_di;

	////////////////////
	// writes.
	////////////////////

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			bypass <= 1'b1;
			sdram_rst <= 1'b1;
			sdram_cke <= 1'b0;
			timing.rp <= 3'd2;
			timing.rcd <= 3'd2;
			timing.cas <= 1'b0;
			timing.rfc <= 4'd8;
			timing.wr <= 2'd2;
			timing.refi <= 11'd740;
		end else if (csr_sel && csr_we) begin
			case (csr_a[1:0])
				reg_sys: begin
					bypass <= wr_word.sys_ctl.bypass;
					sdram_rst <= wr_word.sys_ctl.sdram_rst;
					sdram_cke <= wr_word.sys_ctl.sdram_cke;
				end
				reg_tim: begin
					timing.rp <= wr_word.timing.rp;
					timing.rcd <= wr_word.timing.rcd;
					timing.cas <= wr_word.timing.cas;
					timing.rfc <= wr_word.timing.rfc;
					timing.wr <= wr_word.timing.wr;
				end
				reg_refi: timing.refi <= wr_word.refi.refi;
				default: begin
					// the command register is handled below.
				end
			endcase
		end
	end

	// software command, present for exactly one cycle after the write.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			cmd_q <= cmd_nop;
			cmd_adr <= 12'd0;
		end else begin
			cmd_q <= cmd_wr ? ~{wr_word.bypass_cmd.cs, wr_word.bypass_cmd.ras,
				wr_word.bypass_cmd.cas, wr_word.bypass_cmd.we} : cmd_nop;
			if (cmd_wr)
				cmd_adr <= wr_word.bypass_cmd.adr;
		end
	end

	always_comb begin
		cmd_adr_ext = '0;
		cmd_adr_ext[sdram_addrdepth-1:0] = sdram_addrdepth'(cmd_adr);
	end

	assign bypass_cmd = make_cmd(cmd_q, 2'b00, cmd_adr_ext);

	////////////////////
	// reads.
	////////////////////

	always_comb begin
		rd_word = '0;
		case (csr_a[1:0])
			reg_sys: begin
				rd_word.sys_ctl.bypass = bypass;
				rd_word.sys_ctl.sdram_rst = sdram_rst;
				rd_word.sys_ctl.sdram_cke = sdram_cke;
			end
			reg_cmd: rd_word.bypass_cmd.adr = cmd_adr; // the command bits read back as zero.
			reg_tim: begin
				rd_word.timing.rp = timing.rp;
				rd_word.timing.rcd = timing.rcd;
				rd_word.timing.cas = timing.cas;
				rd_word.timing.rfc = timing.rfc;
				rd_word.timing.wr = timing.wr;
			end
			default: rd_word.refi.refi = timing.refi;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			csr_do <= 16'd0;
		else
			csr_do <= csr_sel ? rd_word : 16'd0;
	end

	// a command reaches the sequencer side only after a write to the command register.
	assert property (@(posedge sys_clk) disable iff (sys_rst)
		!cmd_wr |=> cmd_code(bypass_cmd) == cmd_nop);

endmodule

`default_nettype wire

// ==== sdram_pkg.sv ====
`default_nettype none

package sdram_pkg;

	localparam int max_addrdepth = 16;

	////////////////////
	// command and timing words.
	////////////////////

	// one command cycle on the sdram pins. users drive the low sdram_addrdepth bits of adr.
	typedef struct packed {
		logic cs_n;
		logic ras_n;
		logic cas_n;
		logic we_n;
		logic [1:0] ba;
		logic [max_addrdepth-1:0] adr;
	} sdram_cmd_t;

	typedef struct packed {
		logic [2:0] rp;
		logic [2:0] rcd;
		logic cas;
		logic [3:0] rfc;
		logic [1:0] wr;
		logic [10:0] refi;
	} sdram_timing_t;

	////////////////////
	// csr word layouts.
	////////////////////

	typedef struct packed {
		logic [12:0] pad;
		logic sdram_cke;
		logic sdram_rst;
		logic bypass;
	} csr_sys_t;

	typedef struct packed {
		logic [11:0] adr;
		logic ras; // the command bits are active high here and inverted on the pins.
		logic cas;
		logic we;
		logic cs;
	} csr_cmd_t;

	typedef struct packed {
		logic [2:0] pad;
		logic [1:0] wr;
		logic [3:0] rfc;
		logic cas;
		logic [2:0] rcd;
		logic [2:0] rp;
	} csr_tim_t;

	typedef struct packed {
		logic [4:0] pad;
		logic [10:0] refi;
	} csr_refi_t;

	typedef union packed {
		csr_sys_t sys_ctl;
		csr_cmd_t bypass_cmd;
		csr_tim_t timing;
		csr_refi_t refi;
	} csr_word_t;

	// {cs_n, ras_n, cas_n, we_n}. idle is a deselect, which the device treats as a nop.
	localparam logic [3:0] cmd_nop = 4'b1111;
	localparam logic [3:0] cmd_active = 4'b0011;
	localparam logic [3:0] cmd_read = 4'b0101;
	localparam logic [3:0] cmd_write = 4'b0100;
	localparam logic [3:0] cmd_precharge = 4'b0010;
	localparam logic [3:0] cmd_refresh = 4'b0001;

	localparam logic [1:0] reg_sys = 2'd0;
	localparam logic [1:0] reg_cmd = 2'd1;
	localparam logic [1:0] reg_tim = 2'd2;
	localparam logic [1:0] reg_refi = 2'd3;

	localparam sdram_cmd_t nop_cmd = {cmd_nop, 2'b00, 16'h0000};

	function automatic sdram_cmd_t make_cmd(input logic [3:0] code, input logic [1:0] ba,
			input logic [max_addrdepth-1:0] adr);
		return {code, ba, adr};
	endfunction

	function automatic logic [3:0] cmd_code(input sdram_cmd_t c);
		return {c.cs_n, c.ras_n, c.cas_n, c.we_n};
	endfunction

endpackage

`default_nettype wire
